//--- list.f
source/outrun_bus_pkg.sv
source/outrun_cab_pkg.sv
source/region_decode.sv
source/cabinet_io.sv
source/adc_mux.sv
source/data_bus_mux.sv
source/outrun_main_io.sv
tb/outrun_main_io_tb.sv

//--- Makefile
TOP = outrun_main_io_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f list.f --top-module $(TOP) -o $(TOP)

run: compile
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir

//--- tb/outrun_main_io_tb.sv
// Testbench for the main board I/O top with random bus accesses and a reference model
`default_nettype none
`timescale 1ns/1ps

module outrun_main_io_tb
    import outrun_bus_pkg::*;
    import outrun_cab_pkg::*;
();

    localparam int n_mixed     = 250;  // Accesses over all regions
    localparam int n_io        = 350;  // Accesses aimed at the I/O page
    localparam int cycle_limit = ((n_mixed + n_io) * 5 + 10) * 3 / 2;

    logic        clk;
    logic        rst;
    bus_req_t    req;
    region_vec_t active;
    cab_in_t     cab;
    word_t       ana_a;
    word_t       ana_b;
    word_t       ram_data;
    word_t       rom_data;
    word_t       char_data;
    word_t       pal_data;
    word_t       obj_data;
    word_t       sub_data;
    chip_sel_t   cs;
    board_ctrl_t ctrl;
    logic        obj_toggle;
    word_t       cpu_din;

    board_ctrl_t model_ctrl;  // Expected control register
    word_t       model_a;     // Expected analog latches
    word_t       model_b;
    int          cycles;
    int unsigned seed;

    outrun_main_io dut_i (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .active     (active),
        .cab        (cab),
        .ana_a      (ana_a),
        .ana_b      (ana_b),
        .ram_data   (ram_data),
        .rom_data   (rom_data),
        .char_data  (char_data),
        .pal_data   (pal_data),
        .obj_data   (obj_data),
        .sub_data   (sub_data),
        .cs         (cs),
        .ctrl       (ctrl),
        .obj_toggle (obj_toggle),
        .cpu_din    (cpu_din)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: the access sequence ran past %0d clock cycles", cycle_limit);
            $display("Something failed");
            $fatal(1);
        end
    end

    task automatic report_mismatch(input string line);
        $display("%s", line);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_cs(input chip_sel_t got, input chip_sel_t exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("Fail at time %0t: %s is %b, expected %b",
                                      $time, what, got, exp));
        end
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("Fail at time %0t: %s is %h, expected %h",
                                      $time, what, got, exp));
        end
    endtask

    task automatic check_ctrl(input board_ctrl_t got, input board_ctrl_t exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("Fail at time %0t: %s is %b, expected %b",
                                      $time, what, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("Fail at time %0t: %s is %b, expected %b",
                                      $time, what, got, exp));
        end
    endtask

    function automatic chip_sel_t decode_selects(input bus_req_t r, input region_vec_t act);
        chip_sel_t s;
        logic      ram_pg;
        logic      strobe;
        s      = '0;
        ram_pg = r.addr[18] && r.addr[17];
        strobe = !(r.dsn[1] && r.dsn[0]);
        if (!r.asn && r.fc != 3'd7) begin
            s.rom      = act[reg_mem] && !ram_pg;
            s.ram      = act[reg_mem] && ram_pg && strobe;
            s.char_ram = act[reg_scr] && r.addr[16];
            s.vram     = act[reg_scr] && !r.addr[16] && strobe;
            s.obj      = act[reg_obj];
            s.pal      = act[reg_pal];
            s.io       = act[reg_io];
            s.sub      = act[reg_sub];
        end
        return s;
    endfunction

    function automatic logic [7:0] convert_adc(input logic [2:0] ch, input logic [2:0] kind,
                                               input logic [7:0] joy, input word_t a,
                                               input word_t b);
        logic [7:0] a_hi;
        logic [7:0] b_hi;
        logic [7:0] v;
        a_hi = {a[14:8], a[14]};
        b_hi = {b[14:8], b[14]};
        v    = 8'hff;
        if (ch == 3'd0) begin
            v = {~a[7], a[6:0]};
            if (!joy[0]) v = 8'he0;
            if (!joy[1]) v = 8'h20;  // Bit 1 has the last word
        end else if (ch == 3'd1) begin
            case (kind)
                ctrl_dual_stick: v = b[15] ? ~b_hi : 8'h00;
                ctrl_trigger:    v = b[7] ? 8'h00 : {b[6:0], b[6]};
                ctrl_wheel:      v = a[15] ? ~a_hi : 8'h00;
                default:         v = 8'h00;
            endcase
            if (!joy[4]) v = 8'hff;
        end else if (ch == 3'd2) begin
            case (kind)
                ctrl_dual_stick, ctrl_trigger: v = b[15] ? 8'h00 : b_hi;
                ctrl_wheel: v = b[15] ? ~b_hi : 8'h00;
                default:    v = 8'h00;
            endcase
            if (!joy[5]) v = 8'hff;
        end
        return v;
    endfunction

    // Low byte seen on an I/O page read
    function automatic logic [7:0] io_read_byte(input bus_addr_t addr, input cab_in_t c,
                                                input board_ctrl_t k, input logic [7:0] adc);
        logic [2:0] group;
        logic [1:0] sel;
        logic [7:0] v;
        group = addr[6:4];
        sel   = addr[2:1];
        v     = 8'hff;
        if (group == 3'd0 && sel == 2'd2) begin
            v = k;
        end else if (group == 3'd1 && sel == 2'd0) begin
            v = {c.coin, ~c.joystick[7], c.joystick[6], c.start[0], c.service, c.dip_test, 1'b1};
        end else if (group == 3'd1 && sel == 2'd2) begin
            v = c.dipsw_a;
        end else if (group == 3'd1 && sel == 2'd3) begin
            v = c.dipsw_b;
        end else if (group == 3'd3) begin
            v = adc;
        end
        return v;
    endfunction

    function automatic word_t read_word(input chip_sel_t s, input logic [7:0] io_byte);
        if (s.ram || s.vram) return ram_data;
        if (s.rom) return rom_data;
        if (s.char_ram) return char_data;
        if (s.pal) return pal_data;
        if (s.obj) return obj_data;
        if (s.sub) return sub_data;
        if (s.io) return {8'hff, io_byte};
        return 16'hffff;
    endfunction

    task automatic new_access(input logic io_page);
        logic [63:0] r;
        r         = {$urandom, $urandom};
        req.asn   = 1'b0;
        req.fc    = r[2:0];
        req.addr  = r[25:3];
        req.rnw   = r[26];
        req.dsn   = r[28:27];
        req.wdata = r[44:29];
        active    = r[50:45];
        if (io_page) begin
            active = '0;
            active[reg_io] = 1'b1;
            case ($urandom % 5)  // Bias toward the mapped groups
                0: begin
                    req.addr[6:4]  = 3'd0;
                    req.addr[2:1]  = 2'd2;              // Control register
                    req.wdata[4:2] = {1'b0, r[52:51]};  // ADC channel 0 to 3
                end
                1: req.addr[6:4] = 3'd1;
                2: req.addr[6:4] = 3'd3;
                3: req.addr[6:4] = 3'd7;
                default: ;
            endcase
        end else if (r[63]) begin
            active = 6'b000001 << ($urandom % 6);
        end
        r         = {$urandom, $urandom};
        cab       = r[32:0];
        if (io_page) begin
            cab.ctrl_type = ctrl_type_t'({1'b0, r[34:33]});  // Known types plus one other
        end
        r         = {$urandom, $urandom};
        ana_a     = r[15:0];
        ana_b     = r[31:16];
        ram_data  = r[47:32];
        rom_data  = r[63:48];
        r         = {$urandom, $urandom};
        char_data = r[15:0];
        pal_data  = r[31:16];
        obj_data  = r[47:32];
        sub_data  = r[63:48];
    endtask

    // Starts 5 ns after an edge, ends 5 ns after the idle edge
    task automatic run_access(input logic io_page);
        chip_sel_t  sel;
        logic [7:0] adc_byte;
        logic [7:0] io_byte;
        word_t      din;
        new_access(io_page);
        sel      = decode_selects(req, active);
        adc_byte = convert_adc(model_ctrl.adc_ch, cab.ctrl_type, cab.joystick, model_a, model_b);
        io_byte  = io_read_byte(req.addr, cab, model_ctrl, adc_byte);
        din      = read_word(sel, io_byte);
        @(posedge clk);
        #1;
        check_cs(cs, sel, "chip selects");
        check_bit(obj_toggle, sel.io && req.addr[6:4] == 3'd7, "obj_toggle");
        if (sel.io && !req.rnw) begin
            if (req.addr[6:4] == 3'd0 && req.addr[2:1] == 2'd2 && !req.dsn[0]) begin
                model_ctrl = req.wdata[7:0];
            end
            if (req.addr[6:4] == 3'd3) begin
                model_a = ana_a;
                model_b = ana_b;
            end
        end
        @(posedge clk);
        #1;
        check_word(cpu_din, din, "cpu_din");
        check_ctrl(ctrl, model_ctrl, "board control");
        repeat (2) @(posedge clk);
        #5;
        req.asn = 1'b1;
        @(posedge clk);
        #1;
        check_cs(cs, '0, "chip selects after asn");
        check_bit(obj_toggle, 1'b0, "obj_toggle when idle");
        #4;
    endtask

    initial begin
        seed = 32'h88c0_2af8;
        void'($urandom(seed));
        clk        = 1'b0;
        rst        = 1'b1;
        cycles     = 0;
        req        = '0;
        req.asn    = 1'b1;
        active     = '0;
        cab        = '0;
        ana_a      = '0;
        ana_b      = '0;
        ram_data   = '0;
        rom_data   = '0;
        char_data  = '0;
        pal_data   = '0;
        obj_data   = '0;
        sub_data   = '0;
        model_ctrl = '{obj_cfg: 2'b00, video_en: 1'b1, adc_ch: adc_wheel,
                       spare: 1'b0, snd_rstb: 1'b1};
        model_a    = '0;
        model_b    = '0;
        repeat (10) @(posedge clk);
        #5;
        rst = 1'b0;
        check_cs(cs, '0, "chip selects after reset");
        check_word(cpu_din, 16'h0000, "cpu_din after reset");
        check_ctrl(ctrl, model_ctrl, "board control after reset");
        for (int i = 0; i < n_mixed; i++) begin
            run_access(1'b0);
        end
        for (int i = 0; i < n_io; i++) begin
            run_access(1'b1);
        end
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/outrun_main_io.sv
// Main board I/O top with region decoder, cabinet I/O, ADC and read data mux
`default_nettype none
`timescale 1ns/1ps

module outrun_main_io
    import outrun_bus_pkg::*;
    import outrun_cab_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  bus_req_t    req,
    input  region_vec_t active,
    input  cab_in_t     cab,
    input  word_t       ana_a,     // Wheel or gas, depending on controller
    input  word_t       ana_b,
    input  word_t       ram_data,
    input  word_t       rom_data,
    input  word_t       char_data,
    input  word_t       pal_data,
    input  word_t       obj_data,
    input  word_t       sub_data,
    output chip_sel_t   cs,
    output board_ctrl_t ctrl,
    output logic        obj_toggle,
    output word_t       cpu_din
);

    logic       adc_wr;
    logic [7:0] adc_dout;
    logic [7:0] cab_dout;

    region_decode u_decode (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .active (active),
        .cs     (cs)
    );

    cabinet_io u_cab (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .io_sel     (cs.io),
        .cab        (cab),
        .adc_dout   (adc_dout),
        .ctrl       (ctrl),
        .adc_wr     (adc_wr),
        .obj_toggle (obj_toggle),
        .cab_dout   (cab_dout)
    );

    adc_mux u_adc (
        .clk       (clk),
        .rst       (rst),
        .adc_wr    (adc_wr),
        .ana_a     (ana_a),
        .ana_b     (ana_b),
        .adc_ch    (ctrl.adc_ch),
        .ctrl_type (cab.ctrl_type),
        .joystick  (cab.joystick),
        .adc_dout  (adc_dout)
    );

    data_bus_mux u_dbus (
        .clk       (clk),
        .rst       (rst),
        .cs        (cs),
        .ram_data  (ram_data),
        .rom_data  (rom_data),
        .char_data (char_data),
        .pal_data  (pal_data),
        .obj_data  (obj_data),
        .sub_data  (sub_data),
        .cab_dout  (cab_dout),
        .cpu_din   (cpu_din)
    );

endmodule

`default_nettype wire

//--- source/data_bus_mux.sv
// Registered CPU read data selection by chip select priority
`default_nettype none
`timescale 1ns/1ps

module data_bus_mux
    import outrun_bus_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  chip_sel_t  cs,
    input  word_t      ram_data,  // Shared by work RAM and VRAM
    input  word_t      rom_data,
    input  word_t      char_data,
    input  word_t      pal_data,
    input  word_t      obj_data,
    input  word_t      sub_data,
    input  wire  [7:0] cab_dout,
    output word_t      cpu_din
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_din <= '0;
        end else if (cs.ram || cs.vram) begin
            cpu_din <= ram_data;
        end else if (cs.rom) begin
            cpu_din <= rom_data;
        end else if (cs.char_ram) begin
            cpu_din <= char_data;
        end else if (cs.pal) begin
            cpu_din <= pal_data;
        end else if (cs.obj) begin
            cpu_din <= obj_data;
        end else if (cs.sub) begin
            cpu_din <= sub_data;
        end else if (cs.io) begin
            cpu_din <= {8'hff, cab_dout}; // I/O chips sit on the low byte
        end else begin
            cpu_din <= 16'hffff;
        end
    end

endmodule

`default_nettype wire

//--- source/adc_mux.sv
// Analog input latch and per-channel ADC conversion with button overrides
`default_nettype none
`timescale 1ns/1ps

module adc_mux
    import outrun_bus_pkg::*;
    import outrun_cab_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        adc_wr,
    input  word_t      ana_a,
    input  word_t      ana_b,
    input  adc_ch_t    adc_ch,
    input  ctrl_type_t ctrl_type,
    input  wire  [7:0] joystick,
    output logic [7:0] adc_dout
);

    word_t lat_a;
    word_t lat_b;

    // Signed high byte folded to 8 bits, LSB copied from bit 14
    function automatic logic [7:0] hi_byte(input word_t w);
        return {w[14:8], w[14]};
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lat_a <= '0;
            lat_b <= '0;
        end else if (adc_wr) begin
            lat_a <= ana_a;
            lat_b <= ana_b;
        end
    end

    always_comb begin
        adc_dout = 8'hff;
        case (adc_ch)
            adc_wheel: begin
                adc_dout = lat_a[7:0] ^ 8'h80; // Centre at 80h
                if (!joystick[0]) adc_dout = 8'he0;
                if (!joystick[1]) adc_dout = 8'h20; // Right wins over left
            end
            adc_gas: begin
                case (ctrl_type)
                    ctrl_dual_stick: adc_dout = lat_b[15] ? ~hi_byte(lat_b) : 8'h00;
                    ctrl_trigger:    adc_dout = lat_b[7] ? 8'h00 : {lat_b[6:0], lat_b[6]};
                    ctrl_wheel:      adc_dout = lat_a[15] ? ~hi_byte(lat_a) : 8'h00;
                    default:         adc_dout = 8'h00;
                endcase
                if (!joystick[4]) adc_dout = 8'hff; // Full throttle button
            end
            adc_brake: begin
                case (ctrl_type)
                    ctrl_dual_stick, ctrl_trigger: adc_dout = lat_b[15] ? 8'h00 : hi_byte(lat_b);
                    ctrl_wheel: adc_dout = lat_b[15] ? ~hi_byte(lat_b) : 8'h00;
                    default:    adc_dout = 8'h00;
                endcase
                if (!joystick[5]) adc_dout = 8'hff;
            end
            default: adc_dout = 8'hff;
        endcase
    end

endmodule

`default_nettype wire

//--- source/cabinet_io.sv
// Cabinet I/O page with switch read mux, ADC strobe and board control register
`default_nettype none
`timescale 1ns/1ps

module cabinet_io
    import outrun_bus_pkg::*;
    import outrun_cab_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  bus_req_t    req,
    input  wire         io_sel,
    input  cab_in_t     cab,
    input  wire  [7:0]  adc_dout,
    output board_ctrl_t ctrl,
    output logic        adc_wr,
    output logic        obj_toggle,
    output logic [7:0]  cab_dout
);

    localparam logic [1:0] ctrl_reg = 2'd2; // Port C of the old PPI

    localparam board_ctrl_t ctrl_reset = '{
        obj_cfg:  2'b00,
        video_en: 1'b1,
        adc_ch:   adc_wheel,
        spare:    1'b0,
        snd_rstb: 1'b1
    };

    io_group_t  group;
    logic [1:0] reg_sel;
    logic       low_write;

    assign group     = io_group_t'(req.addr[6:4]);
    assign reg_sel   = req.addr[2:1];
    assign low_write = io_sel && !req.rnw && !req.dsn[0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl <= ctrl_reset;
        end else if (low_write && group == io_ctrl && reg_sel == ctrl_reg) begin
            ctrl <= req.wdata[7:0];
        end
    end

    assign adc_wr     = io_sel && group == io_adc && !req.rnw; // Starts a conversion
    assign obj_toggle = io_sel && group == io_toggle;          // Object buffer swap

    always_comb begin
        cab_dout = 8'hff; // Open bus
        if (io_sel) begin
            case (group)
                io_ctrl: if (reg_sel == ctrl_reg) cab_dout = ctrl;
                io_switch: begin
                    case (reg_sel)
                        2'd0: cab_dout = {cab.coin, ~cab.joystick[7], cab.joystick[6],
                                          cab.start[0], cab.service, cab.dip_test, 1'b1};
                        2'd2: cab_dout = cab.dipsw_a;
                        2'd3: cab_dout = cab.dipsw_b;
                        default: cab_dout = 8'hff;
                    endcase
                end
                io_adc: cab_dout = adc_dout;
                default: cab_dout = 8'hff;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/region_decode.sv
// Registered chip select decoder driven by the mapper region bits
`default_nettype none
`timescale 1ns/1ps

module region_decode
    import outrun_bus_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  bus_req_t    req,
    input  region_vec_t active,
    output chip_sel_t   cs
);

    chip_sel_t cs_next;
    logic      bus_valid;
    logic      any_strobe;
    logic      ram_page;

    // Interrupt acknowledge cycles (FC 7) select nothing
    assign bus_valid  = !req.asn && req.fc != 3'd7;
    assign any_strobe = req.dsn != 2'b11;
    assign ram_page   = req.addr[18:17] == 2'b11; // Work RAM at $60000 in the memory region

    always_comb begin
        cs_next = '0;
        if (bus_valid) begin
            cs_next.rom      = active[reg_mem] && !ram_page;
            cs_next.ram      = active[reg_mem] && ram_page && any_strobe;
            cs_next.char_ram = active[reg_scr] && req.addr[16];
            cs_next.vram     = active[reg_scr] && !req.addr[16] && any_strobe;
            cs_next.obj      = active[reg_obj];
            cs_next.pal      = active[reg_pal];
            cs_next.io       = active[reg_io];
            cs_next.sub      = active[reg_sub];
        end
    end

    // One edge of latency, clears on the edge after asn rises
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cs <= '0;
        end else begin
            cs <= cs_next;
        end
    end

endmodule

`default_nettype wire

//--- source/outrun_cab_pkg.sv
// Cabinet inputs, board control register, controller and I/O group types
`default_nettype none

package outrun_cab_pkg;

    // Analog controller fitted to the cabinet
    typedef enum logic [2:0] {
        ctrl_dual_stick = 3'd0,
        ctrl_trigger    = 3'd1,
        ctrl_wheel      = 3'd2
    } ctrl_type_t;

    // ADC channel picked by the board control register
    typedef enum logic [2:0] {
        adc_wheel = 3'd0,
        adc_gas   = 3'd1,
        adc_brake = 3'd2
    } adc_ch_t;

    typedef struct packed {
        logic [7:0] joystick;  // Active low buttons
        logic [1:0] start;
        logic [1:0] coin;
        logic       service;
        logic       dip_test;
        logic [7:0] dipsw_a;
        logic [7:0] dipsw_b;
        ctrl_type_t ctrl_type;
    } cab_in_t;

    // Same bit layout as the old PPI port C
    typedef struct packed {
        logic [1:0] obj_cfg;   // Bit 1 to object engine, bit 0 to colour mixer
        logic       video_en;
        adc_ch_t    adc_ch;
        logic       spare;
        logic       snd_rstb;
    } board_ctrl_t;

    // I/O page groups, address bits 6:4
    typedef enum logic [2:0] {
        io_ctrl   = 3'd0,
        io_switch = 3'd1,
        io_adc    = 3'd3,
        io_toggle = 3'd7
    } io_group_t;

endpackage

`default_nettype wire

//--- source/outrun_bus_pkg.sv
// Bus request, data word, chip select and mapper region types
`default_nettype none

package outrun_bus_pkg;

    typedef logic [15:0] word_t;

    // 68000 word address, A0 is carried by the data strobes
    typedef logic [23:1] bus_addr_t;

    typedef struct packed {
        logic       asn;   // Address strobe, active low
        logic [2:0] fc;    // Function code
        bus_addr_t  addr;
        logic       rnw;   // High for reads
        logic [1:0] dsn;   // {UDS, LDS}, active low
        word_t      wdata;
    } bus_req_t;

    // Mapper regions, CSS lines on the board
    typedef logic [2:0] region_idx_t;

    localparam region_idx_t reg_mem = 3'd0;
    localparam region_idx_t reg_scr = 3'd1;
    localparam region_idx_t reg_pal = 3'd2;
    localparam region_idx_t reg_obj = 3'd3;
    localparam region_idx_t reg_io  = 3'd4;
    localparam region_idx_t reg_sub = 3'd5;

    typedef logic [5:0] region_vec_t; // One bit per region, indexed as above

    typedef struct packed {
        logic rom;
        logic ram;
        logic char_ram;
        logic vram;
        logic obj;
        logic pal;
        logic io;
        logic sub;
    } chip_sel_t;

endpackage

`default_nettype wire
